/* src/rv32i_types_pkg.sv */
package rv32i_types_pkg;

    // one data word of the rv32i datapath
    typedef logic [31:0] rv32i_word;

    // architectural register index, x0 to x31
    typedef logic [4:0] rv32i_reg;

    // loaded word as it comes back from data memory
    // the lane picks a view by load size and a slot by address low bits
    typedef union packed {
        // lw sees the whole word
        rv32i_word word;
        // lh, lhu: half[0] is bits 15:0
        logic [1:0][15:0] half;
        // lb, lbu: bytes[0] is bits 7:0
        logic [3:0][7:0] bytes;
    } mem_word_u;

endpackage : rv32i_types_pkg

/* src/rv32i_ctrl_pkg.sv */
package rv32i_ctrl_pkg;

    // writeback source select
    // loads carry their size and signedness in the select itself
    typedef enum logic [3:0] {
        alu_out  = 4'd0,
        br_en    = 4'd1,
        u_imm    = 4'd2,
        lw       = 4'd3,
        pc_plus4 = 4'd4,
        lh       = 4'd5,
        lhu      = 4'd6,
        lb       = 4'd7,
        lbu      = 4'd8
    } regfilemux_sel_t;

    // writeback part of the control word, 5 bits
    typedef struct packed {
        logic            load_regfile;
        regfilemux_sel_t regfilemux_sel;
    } wb_ctrl_t;

endpackage : rv32i_ctrl_pkg

/* src/wb_lane_if.sv */
`timescale 1ns/10ps

interface wb_lane_if;
    import rv32i_types_pkg::*;
    import rv32i_ctrl_pkg::*;

    // one retiring instruction as seen by a writeback lane
    wb_ctrl_t   ctrl;
    rv32i_reg   rd;
    rv32i_word  alu_out;
    mem_word_u  mem_rdata;
    // low bits of the data address, only used for load alignment
    logic [1:0] mem_addr_lo;
    rv32i_word  pc;
    rv32i_word  u_imm;
    logic       br_en;

    // retire stage side
    modport retire (
        output ctrl,
        output rd,
        output alu_out,
        output mem_rdata,
        output mem_addr_lo,
        output pc,
        output u_imm,
        output br_en
    );

    // writeback lane side
    modport lane (
        input ctrl,
        input rd,
        input alu_out,
        input mem_rdata,
        input mem_addr_lo,
        input pc,
        input u_imm,
        input br_en
    );

endinterface : wb_lane_if

/* src/wb_retire_stage.sv */
`timescale 1ns/10ps

module wb_retire_stage #(
    parameter int LANES = 2
) (
    input  logic                                  clk,
    input  logic                                  reset_i,
    input  logic [LANES-1:0]                      retire_valid_i,
    input  rv32i_ctrl_pkg::wb_ctrl_t  [LANES-1:0] ctrl_i,
    input  rv32i_types_pkg::rv32i_reg [LANES-1:0] rd_i,
    input  rv32i_types_pkg::rv32i_word [LANES-1:0] alu_out_i,
    input  rv32i_types_pkg::rv32i_word [LANES-1:0] mem_rdata_i,
    input  logic [LANES-1:0][1:0]                 mem_addr_lo_i,
    input  rv32i_types_pkg::rv32i_word [LANES-1:0] pc_i,
    input  rv32i_types_pkg::rv32i_word [LANES-1:0] u_imm_i,
    input  logic [LANES-1:0]                      br_en_i,
    wb_lane_if.retire                             lanes [LANES]
);

    for (genvar l = 0; l < LANES; l++) begin : g_lane

        // control, an invalid slot becomes a no-write alu_out lane
        always_ff @(posedge clk) begin
            if (reset_i) begin
                lanes[l].ctrl <= '0;
            end else if (retire_valid_i[l]) begin
                lanes[l].ctrl <= ctrl_i[l];
            end else begin
                lanes[l].ctrl <= '0;
            end
        end

        // payload follows the lane every cycle
        always_ff @(posedge clk) begin
            lanes[l].rd          <= rd_i[l];
            lanes[l].alu_out     <= alu_out_i[l];
            lanes[l].mem_rdata   <= mem_rdata_i[l];
            lanes[l].mem_addr_lo <= mem_addr_lo_i[l];
            lanes[l].pc          <= pc_i[l];
            lanes[l].u_imm       <= u_imm_i[l];
            lanes[l].br_en       <= br_en_i[l];
        end

    end

endmodule : wb_retire_stage

/* src/wb_lane.sv */
`timescale 1ns/10ps

module wb_lane (
    input  logic                       clk,
    input  logic                       reset_i,
    wb_lane_if.lane                    retire,
    output logic                       we_o,
    output rv32i_types_pkg::rv32i_reg  rd_o,
    output rv32i_types_pkg::rv32i_word data_o
);
    import rv32i_types_pkg::*;
    import rv32i_ctrl_pkg::*;

    mem_word_u rdata;
    logic [15:0] ld_half;
    logic [7:0] ld_byte;
    rv32i_word wb_data;

    assign rdata = retire.mem_rdata;

    // slot selection, halfword loads are always aligned
    assign ld_half = rdata.half[retire.mem_addr_lo[1]];
    assign ld_byte = rdata.bytes[retire.mem_addr_lo];

    // writeback source mux
    always_comb begin
        unique case (retire.ctrl.regfilemux_sel)
            alu_out: begin
                wb_data = retire.alu_out;
            end
            br_en: begin
                wb_data = {31'd0, retire.br_en};
            end
            u_imm: begin
                wb_data = retire.u_imm;
            end
            pc_plus4: begin
                wb_data = retire.pc + 32'd4;
            end
            lw: begin
                wb_data = rdata.word;
            end
            lh: begin
                wb_data = {{16{ld_half[15]}}, ld_half};
            end
            lhu: begin
                wb_data = {16'd0, ld_half};
            end
            lb: begin
                wb_data = {{24{ld_byte[7]}}, ld_byte};
            end
            lbu: begin
                wb_data = {24'd0, ld_byte};
            end
            default: begin
                // not reachable from the retire stage
                wb_data = retire.alu_out;
            end
        endcase
    end

    // write strobe, the retire stage already folded valid into it
    always_ff @(posedge clk) begin
        if (reset_i) begin
            we_o <= 1'b0;
        end else begin
            we_o <= retire.ctrl.load_regfile;
        end
    end

    // commit payload
    always_ff @(posedge clk) begin
        rd_o   <= retire.rd;
        data_o <= wb_data;
    end

endmodule : wb_lane

/* src/wb_regfile.sv */
`timescale 1ns/10ps

module wb_regfile #(
    parameter int LANES = 2
) (
    input  logic                                   clk,
    input  logic                                   reset_i,
    input  logic [LANES-1:0]                       we_i,
    input  rv32i_types_pkg::rv32i_reg  [LANES-1:0] rd_i,
    input  rv32i_types_pkg::rv32i_word [LANES-1:0] data_i,
    input  rv32i_types_pkg::rv32i_reg              rs1_i,
    input  rv32i_types_pkg::rv32i_reg              rs2_i,
    output rv32i_types_pkg::rv32i_word             rs1_data_o,
    output rv32i_types_pkg::rv32i_word             rs2_data_o
);
    import rv32i_types_pkg::*;

    // x0 has no storage
    rv32i_word regs [31:1];

    // later lanes overwrite earlier ones, so the highest lane wins
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int r = 1; r < 32; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int l = 0; l < LANES; l++) begin
                if (we_i[l] && (rd_i[l] != '0)) begin
                    regs[rd_i[l]] <= data_i[l];
                end
            end
        end
    end

    // combinational reads
    always_comb begin
        if (rs1_i == '0) begin
            rs1_data_o = '0;
        end else begin
            rs1_data_o = regs[rs1_i];
        end
    end

    always_comb begin
        if (rs2_i == '0) begin
            rs2_data_o = '0;
        end else begin
            rs2_data_o = regs[rs2_i];
        end
    end

endmodule : wb_regfile

/* src/wb_cluster_top.sv */
`timescale 1ns/10ps

module wb_cluster_top #(
    parameter int LANES = 2
) (
    input  logic                                   clk,
    input  logic                                   reset_i,
    // retire bundle, one slot per lane
    input  logic [LANES-1:0]                       retire_valid_i,
    input  rv32i_ctrl_pkg::wb_ctrl_t   [LANES-1:0] ctrl_i,
    input  rv32i_types_pkg::rv32i_reg  [LANES-1:0] rd_i,
    input  rv32i_types_pkg::rv32i_word [LANES-1:0] alu_out_i,
    input  rv32i_types_pkg::rv32i_word [LANES-1:0] mem_rdata_i,
    input  logic [LANES-1:0][1:0]                  mem_addr_lo_i,
    input  rv32i_types_pkg::rv32i_word [LANES-1:0] pc_i,
    input  rv32i_types_pkg::rv32i_word [LANES-1:0] u_imm_i,
    input  logic [LANES-1:0]                       br_en_i,
    // register read ports
    input  rv32i_types_pkg::rv32i_reg              rs1_i,
    input  rv32i_types_pkg::rv32i_reg              rs2_i,
    output rv32i_types_pkg::rv32i_word             rs1_data_o,
    output rv32i_types_pkg::rv32i_word             rs2_data_o,
    // commit ports, same signals that feed the register file
    output logic [LANES-1:0]                       commit_we_o,
    output rv32i_types_pkg::rv32i_reg  [LANES-1:0] commit_rd_o,
    output rv32i_types_pkg::rv32i_word [LANES-1:0] commit_data_o
);

    wb_lane_if lanes_if [LANES] ();

    wb_retire_stage #(
        .LANES(LANES)
    ) wb_retire_stage_i (
        .clk           (clk),
        .reset_i       (reset_i),
        .retire_valid_i(retire_valid_i),
        .ctrl_i        (ctrl_i),
        .rd_i          (rd_i),
        .alu_out_i     (alu_out_i),
        .mem_rdata_i   (mem_rdata_i),
        .mem_addr_lo_i (mem_addr_lo_i),
        .pc_i          (pc_i),
        .u_imm_i       (u_imm_i),
        .br_en_i       (br_en_i),
        .lanes         (lanes_if)
    );

    for (genvar l = 0; l < LANES; l++) begin : g_lane
        wb_lane wb_lane_i (
            .clk    (clk),
            .reset_i(reset_i),
            .retire (lanes_if[l]),
            .we_o   (commit_we_o[l]),
            .rd_o   (commit_rd_o[l]),
            .data_o (commit_data_o[l])
        );
    end

    wb_regfile #(
        .LANES(LANES)
    ) wb_regfile_i (
        .clk       (clk),
        .reset_i   (reset_i),
        .we_i      (commit_we_o),
        .rd_i      (commit_rd_o),
        .data_i    (commit_data_o),
        .rs1_i     (rs1_i),
        .rs2_i     (rs2_i),
        .rs1_data_o(rs1_data_o),
        .rs2_data_o(rs2_data_o)
    );

endmodule : wb_cluster_top

/* dv/wb_cluster_assertions.sv */
`timescale 1ns/10ps

module wb_cluster_assertions (
    input logic                            clk,
    input logic                            reset_i,
    input logic                            we_o,
    input rv32i_ctrl_pkg::regfilemux_sel_t sel,
    input logic [1:0]                      addr_lo
);
    import rv32i_ctrl_pkg::*;

    // failed assertions in this lane
    int fail_count = 0;

    // lane must come out of reset with its write strobe low
    property p_we_low_after_reset;
        @(posedge clk) reset_i |=> !we_o;
    endproperty

    // halfword loads are aligned by the issuing side
    property p_half_aligned;
        @(posedge clk) disable iff (reset_i)
            (sel inside {lh, lhu}) |-> !addr_lo[0];
    endproperty

    // only defined writeback sources reach the lane
    property p_sel_in_range;
        @(posedge clk) disable iff (reset_i)
            sel inside {alu_out, br_en, u_imm, lw, pc_plus4, lh, lhu, lb, lbu};
    endproperty

    a_we_low_after_reset: assert property (p_we_low_after_reset)
        else begin
            $error("write strobe not low in the cycle after reset");
            fail_count++;
        end

    a_half_aligned: assert property (p_half_aligned)
        else begin
            $error("halfword load with odd address offset %0d", addr_lo);
            fail_count++;
        end

    a_sel_in_range: assert property (p_sel_in_range)
        else begin
            $error("writeback select %0d outside the defined sources", sel);
            fail_count++;
        end

endmodule : wb_cluster_assertions

/* dv/wb_cluster_tb.sv */
`timescale 1ns/10ps

module wb_cluster_tb;
    import rv32i_types_pkg::*;
    import rv32i_ctrl_pkg::*;

    localparam int LANES = 2;
    localparam int RANDOM_CYCLES = 400;
    localparam int WAIT_LIMIT = 10;

    // one expected commit bundle and the cycle it is due
    typedef struct {
        logic [LANES-1:0]             we;
        logic [LANES-1:0][4:0]        rd;
        logic [LANES-1:0][31:0]       data;
        int                           due;
    } commit_t;

    logic                    clk;
    logic                    reset_i;
    logic [LANES-1:0]        retire_valid_i;
    wb_ctrl_t   [LANES-1:0]  ctrl_i;
    rv32i_reg   [LANES-1:0]  rd_i;
    rv32i_word  [LANES-1:0]  alu_out_i;
    rv32i_word  [LANES-1:0]  mem_rdata_i;
    logic [LANES-1:0][1:0]   mem_addr_lo_i;
    rv32i_word  [LANES-1:0]  pc_i;
    rv32i_word  [LANES-1:0]  u_imm_i;
    logic [LANES-1:0]        br_en_i;
    rv32i_reg                rs1_i;
    rv32i_reg                rs2_i;
    rv32i_word               rs1_data_o;
    rv32i_word               rs2_data_o;
    logic [LANES-1:0]        commit_we_o;
    rv32i_reg   [LANES-1:0]  commit_rd_o;
    rv32i_word  [LANES-1:0]  commit_data_o;

    integer    seed = 32'h9491;
    int        cycle = 0;
    int        error_count = 0;
    int        check_count = 0;
    int        assert_fails = 0;
    bit        timed_out = 1'b0;
    commit_t   exp_q [$];
    rv32i_word shadow [32];
    rv32i_reg  last_rd = '0;
    bit        seen [9][4];

    wb_cluster_top #(
        .LANES(LANES)
    ) wb_cluster_top_i (
        .clk           (clk),
        .reset_i       (reset_i),
        .retire_valid_i(retire_valid_i),
        .ctrl_i        (ctrl_i),
        .rd_i          (rd_i),
        .alu_out_i     (alu_out_i),
        .mem_rdata_i   (mem_rdata_i),
        .mem_addr_lo_i (mem_addr_lo_i),
        .pc_i          (pc_i),
        .u_imm_i       (u_imm_i),
        .br_en_i       (br_en_i),
        .rs1_i         (rs1_i),
        .rs2_i         (rs2_i),
        .rs1_data_o    (rs1_data_o),
        .rs2_data_o    (rs2_data_o),
        .commit_we_o   (commit_we_o),
        .commit_rd_o   (commit_rd_o),
        .commit_data_o (commit_data_o)
    );

    bind wb_lane wb_cluster_assertions wb_cluster_assertions_i (
        .clk         (clk),
        .reset_i     (reset_i),
        .we_o        (we_o),
        .sel         (retire.ctrl.regfilemux_sel),
        .addr_lo     (retire.mem_addr_lo)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAILED %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    // writeback value built straight from the source and load rules
    function automatic rv32i_word expected_data(input logic [3:0] sel, input rv32i_word alu_v,
                                                input logic br_v, input rv32i_word uimm_v,
                                                input rv32i_word pc_v, input rv32i_word rdata_v,
                                                input logic [1:0] addr_v);
        logic [15:0] h;
        logic [7:0]  b;
        h = 16'(rdata_v >> {addr_v[1], 4'b0000});
        b = 8'(rdata_v >> {addr_v, 3'b000});
        case (regfilemux_sel_t'(sel))
            alu_out:  return alu_v;
            br_en:    return {31'd0, br_v};
            u_imm:    return uimm_v;
            pc_plus4: return pc_v + 32'd4;
            lw:       return rdata_v;
            lh:       return {{16{h[15]}}, h};
            lhu:      return {16'd0, h};
            lb:       return {{24{b[7]}}, b};
            lbu:      return {24'd0, b};
            default:  return 'x;
        endcase
    endfunction

    // failures flagged by the bound checkers of both lanes
    function automatic int assertion_failures();
        return wb_cluster_top_i.g_lane[0].wb_lane_i.wb_cluster_assertions_i.fail_count
             + wb_cluster_top_i.g_lane[1].wb_lane_i.wb_cluster_assertions_i.fail_count;
    endfunction

    task automatic drive_lanes(input bit allow_valid);
        commit_t    exp;
        wb_ctrl_t   c;
        logic [3:0] sel;
        logic [1:0] addr;
        logic       valid;
        logic       br_v;
        rv32i_reg   rd_v;
        rv32i_reg   lane0_rd;
        rv32i_word  alu_v;
        rv32i_word  rdata_v;
        rv32i_word  pc_v;
        rv32i_word  uimm_v;
        exp.due = cycle + 2;
        lane0_rd = '0;
        for (int l = 0; l < LANES; l++) begin
            valid = allow_valid && (($random(seed) & 7) != 0);
            sel = 4'($unsigned($random(seed)) % 9);
            c.load_regfile = (($random(seed) & 7) != 0);
            c.regfilemux_sel = regfilemux_sel_t'(sel);
            rd_v = 5'($random(seed));
            // same destination on both lanes now and then
            if (l > 0 && ($random(seed) & 3) == 0) begin
                rd_v = lane0_rd;
            end
            if (l == 0) begin
                lane0_rd = rd_v;
            end
            alu_v = $random(seed);
            rdata_v = $random(seed);
            pc_v = $random(seed);
            uimm_v = $random(seed) & 32'hffff_f000;
            br_v = 1'($random(seed));
            addr = 2'($random(seed));
            // halfword loads stay aligned
            if (c.regfilemux_sel inside {lh, lhu}) begin
                addr[0] = 1'b0;
            end
            retire_valid_i[l] <= valid;
            ctrl_i[l]         <= c;
            rd_i[l]           <= rd_v;
            alu_out_i[l]      <= alu_v;
            mem_rdata_i[l]    <= rdata_v;
            mem_addr_lo_i[l]  <= addr;
            pc_i[l]           <= pc_v;
            u_imm_i[l]        <= uimm_v;
            br_en_i[l]        <= br_v;
            exp.we[l] = valid && c.load_regfile;
            exp.rd[l] = rd_v;
            exp.data[l] = expected_data(sel, alu_v, br_v, uimm_v, pc_v, rdata_v, addr);
            if (exp.we[l]) begin
                seen[sel][addr] = 1'b1;
            end
        end
        rs1_i <= 5'($random(seed));
        if (allow_valid) begin
            // read back the register written on the coming edge
            rs2_i <= last_rd;
        end else begin
            rs2_i <= 5'($random(seed));
        end
        exp_q.push_back(exp);
    endtask

    task automatic check_outputs();
        commit_t exp;
        check_value("rs1_data_o", rs1_data_o, shadow[rs1_i]);
        check_value("rs2_data_o", rs2_data_o, shadow[rs2_i]);
        if (exp_q.size() > 0 && exp_q[0].due == cycle) begin
            exp = exp_q.pop_front();
            for (int l = 0; l < LANES; l++) begin
                check_value($sformatf("commit_we_o[%0d]", l), commit_we_o[l], exp.we[l]);
                if (exp.we[l]) begin
                    check_value($sformatf("commit_rd_o[%0d]", l), commit_rd_o[l], exp.rd[l]);
                    check_value($sformatf("commit_data_o[%0d]", l), commit_data_o[l],
                                exp.data[l]);
                end
            end
            // ascending lane order so the higher lane wins and x0 is never written
            for (int l = 0; l < LANES; l++) begin
                if (exp.we[l] && exp.rd[l] != 5'd0) begin
                    shadow[exp.rd[l]] = exp.data[l];
                    last_rd = exp.rd[l];
                end
            end
        end
    endtask

    task automatic step_cycle(input bit allow_valid);
        @(posedge clk);
        cycle++;
        drive_lanes(allow_valid);
        @(negedge clk);
        check_outputs();
    endtask

    task automatic check_reset_state();
        @(negedge clk);
        check_value("commit_we_o", commit_we_o, '0);
    endtask

    task automatic drain_pipeline();
        int n;
        n = 0;
        while (exp_q.size() > 0 && n < WAIT_LIMIT) begin
            @(posedge clk);
            cycle++;
            // no new retires, only the queued commits are checked
            retire_valid_i <= '0;
            @(negedge clk);
            check_outputs();
            n++;
        end
        if (exp_q.size() > 0) begin
            $display("timeout: %0d expected commits never arrived", exp_q.size());
            error_count++;
            timed_out = 1'b1;
        end
    endtask

    task automatic check_load_coverage();
        for (int s = 3; s < 9; s++) begin
            for (int a = 0; a < 4; a++) begin
                if (s != 4 && !(s inside {5, 6} && a[0]) && !seen[s][a]) begin
                    $display("load select %0d at address offset %0d was never exercised", s, a);
                    error_count++;
                end
            end
        end
    endtask

    initial begin
        reset_i = 1'b1;
        retire_valid_i = '0;
        ctrl_i = '0;
        rd_i = '0;
        alu_out_i = '0;
        mem_rdata_i = '0;
        mem_addr_lo_i = '0;
        pc_i = '0;
        u_imm_i = '0;
        br_en_i = '0;
        rs1_i = '0;
        rs2_i = '0;
        for (int r = 0; r < 32; r++) begin
            shadow[r] = '0;
        end
        repeat (2) @(posedge clk);
        reset_i <= 1'b0;
        check_reset_state();
        // idle lanes first so every register still reads zero
        repeat (4) step_cycle(1'b0);
        repeat (RANDOM_CYCLES) step_cycle(1'b1);
        drain_pipeline();
        check_load_coverage();
        assert_fails = assertion_failures();
        $display("%0d checks, %0d errors, %0d assertion failures",
                 check_count, error_count, assert_fails);
        if (timed_out || error_count != 0 || assert_fails != 0) begin
            $display("Test failed");
        end else begin
            $display("Test completed successfully");
        end
        $finish;
    end

endmodule : wb_cluster_tb

/* all.f */
src/rv32i_types_pkg.sv
src/rv32i_ctrl_pkg.sv
src/wb_lane_if.sv
src/wb_retire_stage.sv
src/wb_lane.sv
src/wb_regfile.sv
src/wb_cluster_top.sv
dv/wb_cluster_assertions.sv
dv/wb_cluster_tb.sv
